/* rtl/fabric_pkg.sv */
/*
 * fabric types and address map
 * request and response words, decoded targets, ROM and scratchpad windows
 */
`default_nettype none

package fabric_pkg;

  // ----------------------------------------
  // bus words
  // ----------------------------------------
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic [3:0]  be;
  } fabric_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } fabric_rsp_t;

  typedef enum logic [1:0] {
    TGT_ROM = 2'd0,
    TGT_SPM = 2'd1,
    TGT_ERR = 2'd2
  } target_e;

  // request with its decoded target attached
  typedef struct packed {
    fabric_req_t req;
    target_e     tgt;
  } decoded_req_t;

  // ----------------------------------------
  // address map
  // ----------------------------------------
  // boot ROM
  localparam logic [31:0] ROM_BASE  = 32'h0001_0000;
  localparam int unsigned ROM_WORDS = 16;

  // scratchpad, stands in for the L2 SPM
  localparam logic [31:0] SPM_BASE  = 32'h8000_0000;
  localparam int unsigned SPM_WORDS = 64;

  // a ROM word reads as ROM_SEED ^ word index
  localparam logic [31:0] ROM_SEED = 32'h5a5a_0000;

endpackage

`default_nettype wire

/* rtl/credit_fifo.sv */
/*
 * credit FIFO
 * circular buffer that hands one credit back to the producer per pop
 */
`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     valid_o,
  output logic     credit_o
);

  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  payload_t      mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          pop;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign valid_o = (count_q != '0);
  assign pop     = pop_i && valid_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // producer never pushes without a credit, so no full check
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
      credit_o <= pop;
    end
  end

endmodule

`default_nettype wire

/* rtl/initiator_port.sv */
/*
 * initiator port
 * buffers requests, decodes the head against the address map, holds after reset
 */
`timescale 1ns/1ns
`default_nettype none

module initiator_port
  import fabric_pkg::*;
#(
  parameter int unsigned REQ_DEPTH   = 4,
  parameter int unsigned HOLD_CYCLES = 0
) (
  input  logic         clk_i,
  input  logic         ndmreset_n,
  input  logic         req_valid_i,
  input  fabric_req_t  req_i,
  output logic         req_credit_o,
  output logic         fwd_valid_o,
  output decoded_req_t fwd_o,
  input  logic         fwd_ready_i
);

  localparam int unsigned HW = $clog2(HOLD_CYCLES + 2);

  fabric_req_t   head;
  logic          head_valid;
  logic [31:0]   rom_off;
  logic [31:0]   spm_off;
  target_e       tgt;
  logic [HW-1:0] hold_q;

  credit_fifo #(
    .payload_t ( fabric_req_t ),
    .DEPTH     ( REQ_DEPTH    )
  ) u_req_fifo (
    .clk_i      ( clk_i                      ),
    .ndmreset_n ( ndmreset_n                 ),
    .push_i     ( req_valid_i                ),
    .data_i     ( req_i                      ),
    .pop_i      ( fwd_valid_o && fwd_ready_i ),
    .data_o     ( head                       ),
    .valid_o    ( head_valid                 ),
    .credit_o   ( req_credit_o               )
  );

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  // unsigned offsets, wrap-around puts low addresses out of range
  assign rom_off = head.addr - ROM_BASE;
  assign spm_off = head.addr - SPM_BASE;

  always_comb begin
    tgt = TGT_ERR;
    if (rom_off < 32'(ROM_WORDS * 4)) begin
      // ROM is read only
      tgt = head.we ? TGT_ERR : TGT_ROM;
    end else if (spm_off < 32'(SPM_WORDS * 4)) begin
      tgt = TGT_SPM;
    end
  end

  assign fwd_o = '{req: head, tgt: tgt};

  // hold window, lets boot code run before debug traffic
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      hold_q <= HW'(HOLD_CYCLES);
    end else if (hold_q != '0) begin
      hold_q <= hold_q - 1'b1;
    end
  end

  assign fwd_valid_o = head_valid && (hold_q == '0);

endmodule

`default_nettype wire

/* rtl/scratchpad.sv */
/*
 * scratchpad memory
 * word addressed, byte lane writes, one cycle registered read
 */
`timescale 1ns/1ns
`default_nettype none

module scratchpad
  import fabric_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         en_i,
  input  logic                         we_i,
  input  logic [3:0]                   be_i,
  input  logic [$clog2(SPM_WORDS)-1:0] word_i,
  input  logic [31:0]                  wdata_i,
  output logic [31:0]                  rdata_o
);

  logic [31:0] mem_q [SPM_WORDS];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem_q[word_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[word_i];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/target_arbiter.sv */
/*
 * target arbiter
 * round-robin between ports, ROM/SPM/error access, credited response return
 */
`timescale 1ns/1ns
`default_nettype none

module target_arbiter
  import fabric_pkg::*;
#(
  parameter int unsigned RSP_CREDITS = 2
) (
  input  logic         clk_i,
  input  logic         ndmreset_n,
  input  logic         host_fwd_valid_i,
  input  decoded_req_t host_fwd_i,
  output logic         host_fwd_ready_o,
  input  logic         dbg_fwd_valid_i,
  input  decoded_req_t dbg_fwd_i,
  output logic         dbg_fwd_ready_o,
  input  logic         host_rsp_credit_i,
  input  logic         dbg_rsp_credit_i,
  output logic         host_rsp_valid_o,
  output fabric_rsp_t  host_rsp_o,
  output logic         dbg_rsp_valid_o,
  output fabric_rsp_t  dbg_rsp_o
);

  localparam int unsigned CW = $clog2(RSP_CREDITS + 1);
  localparam int unsigned RW = $clog2(ROM_WORDS);
  localparam int unsigned SW = $clog2(SPM_WORDS);

  // index 0 is the host port, index 1 the debug port
  logic [1:0]    fwd_valid;
  logic [1:0]    elig;
  logic [1:0]    grant;
  logic [1:0]    rsp_credit;
  logic [1:0]    rsp_valid;
  decoded_req_t  fwd [2];
  fabric_rsp_t   rsp_out [2];
  decoded_req_t  sel;
  logic          prio_q;
  logic          acc_valid_q;
  logic          acc_port_q;
  logic          acc_we_q;
  target_e       acc_tgt_q;
  logic [RW-1:0] acc_idx_q;
  logic [31:0]   spm_rdata;
  fabric_rsp_t   acc_rsp;

  assign fwd_valid  = {dbg_fwd_valid_i, host_fwd_valid_i};
  assign fwd[0]     = host_fwd_i;
  assign fwd[1]     = dbg_fwd_i;
  assign rsp_credit = {dbg_rsp_credit_i, host_rsp_credit_i};

  // ----------------------------------------
  // round-robin grant
  // ----------------------------------------
  assign grant[0] = elig[0] && (!elig[1] || !prio_q);
  assign grant[1] = elig[1] && !grant[0];
  assign sel      = grant[1] ? fwd[1] : fwd[0];

  assign host_fwd_ready_o = grant[0];
  assign dbg_fwd_ready_o  = grant[1];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      prio_q      <= 1'b0;
      acc_valid_q <= 1'b0;
    end else begin
      if (grant[0]) begin
        prio_q <= 1'b1;
      end else if (grant[1]) begin
        prio_q <= 1'b0;
      end
      acc_valid_q <= |grant;
    end
  end

  always_ff @(posedge clk_i) begin
    if (|grant) begin
      acc_port_q <= grant[1];
      acc_we_q   <= sel.req.we;
      acc_tgt_q  <= sel.tgt;
      acc_idx_q  <= sel.req.addr[RW+1:2];
    end
  end

  // ----------------------------------------
  // access stage
  // ----------------------------------------
  scratchpad u_spm (
    .clk_i   ( clk_i                           ),
    .en_i    ( (|grant) && (sel.tgt == TGT_SPM) ),
    .we_i    ( sel.req.we                      ),
    .be_i    ( sel.req.be                      ),
    .word_i  ( sel.req.addr[SW+1:2]            ),
    .wdata_i ( sel.req.wdata                   ),
    .rdata_o ( spm_rdata                       )
  );

  always_comb begin
    acc_rsp = '{rdata: '0, err: 1'b0};
    case (acc_tgt_q)
      TGT_ROM: acc_rsp.rdata = ROM_SEED ^ 32'(acc_idx_q);
      // writes answer with zero data
      TGT_SPM: acc_rsp.rdata = acc_we_q ? '0 : spm_rdata;
      default: acc_rsp.err = 1'b1;
    endcase
  end

  // ----------------------------------------
  // per-port response return
  // ----------------------------------------
  for (genvar p = 0; p < 2; p++) begin : g_rsp
    logic [CW-1:0] out_q;
    logic [CW-1:0] cnt_q;
    logic          rsp_pend;
    logic          freed;

    credit_fifo #(
      .payload_t ( fabric_rsp_t ),
      .DEPTH     ( RSP_CREDITS  )
    ) u_rsp_fifo (
      .clk_i      ( clk_i                                ),
      .ndmreset_n ( ndmreset_n                           ),
      .push_i     ( acc_valid_q && (acc_port_q == 1'(p)) ),
      .data_i     ( acc_rsp                              ),
      .pop_i      ( rsp_valid[p]                         ),
      .data_o     ( rsp_out[p]                           ),
      .valid_o    ( rsp_pend                             ),
      .credit_o   ( freed                                )
    );

    // granted and not yet drained, covers the access in flight
    assign elig[p]      = fwd_valid[p] && (out_q < CW'(RSP_CREDITS));
    assign rsp_valid[p] = rsp_pend && (cnt_q != '0);

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
      if (!ndmreset_n) begin
        out_q <= '0;
        cnt_q <= CW'(RSP_CREDITS);
      end else begin
        if (grant[p] && !freed) begin
          out_q <= out_q + 1'b1;
        end else if (freed && !grant[p]) begin
          out_q <= out_q - 1'b1;
        end
        if (rsp_credit[p] && !rsp_valid[p]) begin
          cnt_q <= cnt_q + 1'b1;
        end else if (rsp_valid[p] && !rsp_credit[p]) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  assign host_rsp_valid_o = rsp_valid[0];
  assign host_rsp_o       = rsp_out[0];
  assign dbg_rsp_valid_o  = rsp_valid[1];
  assign dbg_rsp_o        = rsp_out[1];

endmodule

`default_nettype wire

/* rtl/soc_fabric_top.sv */
/*
 * request fabric top level
 * host and debug initiator ports sharing one target arbiter
 */
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_top
  import fabric_pkg::*;
#(
  parameter int unsigned REQ_DEPTH         = 4,
  parameter int unsigned RSP_CREDITS       = 2,
  parameter int unsigned DEBUG_HOLD_CYCLES = 20
) (
  input  logic        clk_i,
  input  logic        ndmreset_n,
  // host port
  input  logic        host_req_valid_i,
  input  fabric_req_t host_req_i,
  input  logic        host_rsp_credit_i,
  output logic        host_req_credit_o,
  output logic        host_rsp_valid_o,
  output fabric_rsp_t host_rsp_o,
  // debug port
  input  logic        dbg_req_valid_i,
  input  fabric_req_t dbg_req_i,
  input  logic        dbg_rsp_credit_i,
  output logic        dbg_req_credit_o,
  output logic        dbg_rsp_valid_o,
  output fabric_rsp_t dbg_rsp_o
);

  logic         host_fwd_valid;
  logic         host_fwd_ready;
  decoded_req_t host_fwd;
  logic         dbg_fwd_valid;
  logic         dbg_fwd_ready;
  decoded_req_t dbg_fwd;

  // host never holds
  initiator_port #(
    .REQ_DEPTH   ( REQ_DEPTH ),
    .HOLD_CYCLES ( 0         )
  ) u_host_port (
    .clk_i        ( clk_i             ),
    .ndmreset_n   ( ndmreset_n        ),
    .req_valid_i  ( host_req_valid_i  ),
    .req_i        ( host_req_i        ),
    .req_credit_o ( host_req_credit_o ),
    .fwd_valid_o  ( host_fwd_valid    ),
    .fwd_o        ( host_fwd          ),
    .fwd_ready_i  ( host_fwd_ready    )
  );

  initiator_port #(
    .REQ_DEPTH   ( REQ_DEPTH         ),
    .HOLD_CYCLES ( DEBUG_HOLD_CYCLES )
  ) u_dbg_port (
    .clk_i        ( clk_i            ),
    .ndmreset_n   ( ndmreset_n       ),
    .req_valid_i  ( dbg_req_valid_i  ),
    .req_i        ( dbg_req_i        ),
    .req_credit_o ( dbg_req_credit_o ),
    .fwd_valid_o  ( dbg_fwd_valid    ),
    .fwd_o        ( dbg_fwd          ),
    .fwd_ready_i  ( dbg_fwd_ready    )
  );

  target_arbiter #(
    .RSP_CREDITS ( RSP_CREDITS )
  ) u_arbiter (
    .clk_i             ( clk_i             ),
    .ndmreset_n        ( ndmreset_n        ),
    .host_fwd_valid_i  ( host_fwd_valid    ),
    .host_fwd_i        ( host_fwd          ),
    .host_fwd_ready_o  ( host_fwd_ready    ),
    .dbg_fwd_valid_i   ( dbg_fwd_valid     ),
    .dbg_fwd_i         ( dbg_fwd           ),
    .dbg_fwd_ready_o   ( dbg_fwd_ready     ),
    .host_rsp_credit_i ( host_rsp_credit_i ),
    .dbg_rsp_credit_i  ( dbg_rsp_credit_i  ),
    .host_rsp_valid_o  ( host_rsp_valid_o  ),
    .host_rsp_o        ( host_rsp_o        ),
    .dbg_rsp_valid_o   ( dbg_rsp_valid_o   ),
    .dbg_rsp_o         ( dbg_rsp_o         )
  );

endmodule

`default_nettype wire

/* verification/soc_fabric_checker.sv */
/*
 * fabric protocol checker
 * credit accounting, debug hold window and reset values on both ports
 */
`timescale 1ns/1ns
`default_nettype none

module soc_fabric_checker #(
  parameter int unsigned RSP_CREDITS       = 2,
  parameter int unsigned DEBUG_HOLD_CYCLES = 20
) (
  input logic       clk_i,
  input logic       ndmreset_n,
  // bit 0 host, bit 1 debug
  input logic [1:0] req_valid_i,
  input logic [1:0] req_credit_i,
  input logic [1:0] rsp_valid_i,
  input logic [1:0] rsp_credit_i
);

  int unsigned cyc_q;
  int unsigned fail_cnt = 0;

  // cycles since reset, saturating past the hold window
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cyc_q <= 0;
    end else if (cyc_q < DEBUG_HOLD_CYCLES + 2) begin
      cyc_q <= cyc_q + 1;
    end
  end

  reset_quiet: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (cyc_q == 0) |-> (req_credit_i == '0 && rsp_valid_i == '0))
    else begin
      $error("credit or response output high in the first cycle after reset");
      fail_cnt++;
    end

  debug_hold: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (cyc_q < DEBUG_HOLD_CYCLES + 2) |-> !rsp_valid_i[1])
    else begin
      $error("debug response inside the hold window");
      fail_cnt++;
    end

  // ----------------------------------------
  // per-port credit accounting
  // ----------------------------------------
  for (genvar p = 0; p < 2; p++) begin : g_port
    int unsigned acc_q;
    int unsigned ret_q;
    int unsigned rsp_cred_q;

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
      if (!ndmreset_n) begin
        acc_q      <= 0;
        ret_q      <= 0;
        rsp_cred_q <= RSP_CREDITS;
      end else begin
        acc_q      <= acc_q + 32'(req_valid_i[p]);
        ret_q      <= ret_q + 32'(req_credit_i[p]);
        rsp_cred_q <= rsp_cred_q + 32'(rsp_credit_i[p]) - 32'(rsp_valid_i[p]);
      end
    end

    credit_bound: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
      (ret_q + 32'(req_credit_i[p])) <= acc_q)
      else begin
        $error("port %0d returned more request credits than requests", p);
        fail_cnt++;
      end

    rsp_needs_credit: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
      rsp_valid_i[p] |-> (rsp_cred_q != 0))
      else begin
        $error("port %0d response sent without a response credit", p);
        fail_cnt++;
      end
  end

endmodule

bind soc_fabric_top soc_fabric_checker #(
  .RSP_CREDITS       ( RSP_CREDITS       ),
  .DEBUG_HOLD_CYCLES ( DEBUG_HOLD_CYCLES )
) u_checker (
  .clk_i        ( clk_i                                  ),
  .ndmreset_n   ( ndmreset_n                             ),
  .req_valid_i  ( {dbg_req_valid_i, host_req_valid_i}    ),
  .req_credit_i ( {dbg_req_credit_o, host_req_credit_o}  ),
  .rsp_valid_i  ( {dbg_rsp_valid_o, host_rsp_valid_o}    ),
  .rsp_credit_i ( {dbg_rsp_credit_i, host_rsp_credit_i}  )
);

`default_nettype wire

/* verification/tb_soc_fabric.sv */
/*
 * testbench for the request fabric
 * random host and debug traffic checked against a reference memory model
 */
`timescale 1ns/1ns
`default_nettype none

module tb_soc_fabric
  import fabric_pkg::*;
();

  localparam int unsigned REQ_DEPTH         = 4;
  localparam int unsigned RSP_CREDITS       = 2;
  localparam int unsigned DEBUG_HOLD_CYCLES = 20;
  localparam int unsigned NUM_REQ           = 60;
  localparam int unsigned CLK_PERIOD        = 20;
  localparam int unsigned TIMEOUT_CYCLES    = 2 * NUM_REQ * 40;
  localparam logic [31:0] LFSR_TAPS         = 32'h8020_0003;

  logic             clk_i = 1'b0;
  logic             ndmreset_n;
  // index 0 is the host port, index 1 the debug port
  logic [1:0]       req_valid;
  logic [1:0]       rsp_credit;
  fabric_req_t      req [2];
  wire logic [1:0]  req_credit;
  wire logic [1:0]  rsp_valid;
  wire fabric_rsp_t rsp [2];

  logic [31:0]          lfsr_state = 32'h8671_63eb;
  logic [31:0]          ref_mem [SPM_WORDS];
  logic [SPM_WORDS-1:0] written = '0;
  fabric_rsp_t          exp_q [2][$];
  string                name_q [2][$];
  int                   req_cred [2];
  int                   owed [2];
  int                   sent [2];
  int                   got [2];
  int                   errors = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  soc_fabric_top #(
    .REQ_DEPTH         ( REQ_DEPTH         ),
    .RSP_CREDITS       ( RSP_CREDITS       ),
    .DEBUG_HOLD_CYCLES ( DEBUG_HOLD_CYCLES )
  ) dut_i (
    .clk_i             ( clk_i         ),
    .ndmreset_n        ( ndmreset_n    ),
    .host_req_valid_i  ( req_valid[0]  ),
    .host_req_i        ( req[0]        ),
    .host_rsp_credit_i ( rsp_credit[0] ),
    .host_req_credit_o ( req_credit[0] ),
    .host_rsp_valid_o  ( rsp_valid[0]  ),
    .host_rsp_o        ( rsp[0]        ),
    .dbg_req_valid_i   ( req_valid[1]  ),
    .dbg_req_i         ( req[1]        ),
    .dbg_rsp_credit_i  ( rsp_credit[1] ),
    .dbg_req_credit_o  ( req_credit[1] ),
    .dbg_rsp_valid_o   ( rsp_valid[1]  ),
    .dbg_rsp_o         ( rsp[1]        )
  );

  // galois LFSR stepped once per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // ----------------------------------------
  // request generation and expected responses
  // ----------------------------------------
  task automatic issue_req(input int p);
    logic [1:0]  kind;
    logic [5:0]  word;
    fabric_req_t rq;
    fabric_rsp_t exp;
    string       name;
    kind     = 2'(next_bits(2));
    // each port owns one half of the scratchpad
    word     = {1'(p), 5'(next_bits(5))};
    rq.wdata = next_bits(32);
    rq.be    = 4'(next_bits(4));
    rq.we    = 1'b0;
    exp      = '{rdata: '0, err: 1'b0};
    // first touch of a word writes all four lanes
    if (kind <= 2'd1 && !written[word]) begin
      kind  = 2'd0;
      rq.be = 4'hf;
    end
    case (kind)
      2'd0: begin
        name    = "spm_write";
        rq.addr = SPM_BASE + 32'(word) * 4;
        rq.we   = 1'b1;
        for (int b = 0; b < 4; b++) begin
          if (rq.be[b]) begin
            ref_mem[word][8*b +: 8] = rq.wdata[8*b +: 8];
          end
        end
        written[word] = 1'b1;
      end
      2'd1: begin
        name      = "spm_read";
        rq.addr   = SPM_BASE + 32'(word) * 4;
        exp.rdata = ref_mem[word];
      end
      2'd2: begin
        name      = "rom_read";
        rq.addr   = ROM_BASE + 32'(word[3:0]) * 4;
        exp.rdata = ROM_SEED ^ 32'(word[3:0]);
      end
      default: begin
        exp.err = 1'b1;
        if (next_bits(1) == 1) begin
          name    = "rom_write";
          rq.addr = ROM_BASE + 32'(word[3:0]) * 4;
          rq.we   = 1'b1;
        end else begin
          name    = "unmapped";
          rq.addr = 32'h2000_0000 + 32'(word) * 4;
        end
      end
    endcase
    req[p] = rq;
    exp_q[p].push_back(exp);
    name_q[p].push_back(name);
  endtask

  task automatic check_rsp(input int p);
    fabric_rsp_t exp;
    string       name;
    owed[p]++;
    got[p]++;
    assert (exp_q[p].size() != 0) else begin
      $display("response on port %0d arrived with no request outstanding", p);
      errors++;
    end
    // the hold window lets host traffic through first
    if (p == 1 && got[1] == 1) begin
      assert (got[0] >= RSP_CREDITS) else begin
        $display("debug port answered before the host port got %0d responses", RSP_CREDITS);
        errors++;
      end
    end
    if (exp_q[p].size() != 0) begin
      exp  = exp_q[p].pop_front();
      name = name_q[p].pop_front();
      assert (rsp[p] === exp) else begin
        $display("ERROR %s port %0d: expected %h actual %h", name, p, exp, rsp[p]);
        errors++;
      end
    end
  endtask

  task automatic serve_port(input int p);
    if (req_credit[p]) begin
      req_cred[p]++;
    end
    if (rsp_valid[p]) begin
      check_rsp(p);
    end
    rsp_credit[p] = 1'b0;
    // host side returns response credits at random
    if (owed[p] > 0 && (p != 0 || next_bits(1) == 1)) begin
      rsp_credit[p] = 1'b1;
      owed[p]--;
    end
    req_valid[p] = 1'b0;
    if (req_cred[p] > 0 && sent[p] < NUM_REQ) begin
      issue_req(p);
      req_valid[p] = 1'b1;
      req_cred[p]--;
      sent[p]++;
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main
    ndmreset_n = 1'b0;
    req_valid  = '0;
    rsp_credit = '0;
    req[0]     = '0;
    req[1]     = '0;
    for (int p = 0; p < 2; p++) begin
      req_cred[p] = REQ_DEPTH;
      owed[p]     = 0;
      sent[p]     = 0;
      got[p]      = 0;
    end
    repeat (2) @(posedge clk_i);
    #2 ndmreset_n = 1'b1;
    while (got[0] < NUM_REQ || got[1] < NUM_REQ) begin
      @(posedge clk_i);
      #2;
      serve_port(0);
      serve_port(1);
    end
    $display("%0d response errors, %0d protocol errors", errors, dut_i.u_checker.fail_cnt);
    if (errors == 0 && dut_i.u_checker.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, %0d host and %0d debug responses of %0d each",
             TIMEOUT_CYCLES, got[0], got[1], NUM_REQ);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/fabric_pkg.sv
rtl/credit_fifo.sv
rtl/initiator_port.sv
rtl/scratchpad.sv
rtl/target_arbiter.sv
rtl/soc_fabric_top.sv
verification/soc_fabric_checker.sv
verification/tb_soc_fabric.sv

/* Bender.yml */
package:
  name: soc_fabric

sources:
  - files:
      - rtl/fabric_pkg.sv
      - rtl/credit_fifo.sv
      - rtl/initiator_port.sv
      - rtl/scratchpad.sv
      - rtl/target_arbiter.sv
      - rtl/soc_fabric_top.sv
  - target: test
    files:
      - verification/soc_fabric_checker.sv
      - verification/tb_soc_fabric.sv
